// File: rtl/pet_pkg.sv
// Shared types and address map for the PET bus controller
// Host addresses are 17 bits and reach the whole 128 KB RAM, CPU addresses are 16 bits
// Select fields are active high, the active-low pins are formed at the top level
`default_nettype none

package pet_pkg;

    // One phase per 16 MHz cycle, 16 phases per 1 MHz CPU cycle
    typedef enum logic [3:0] {
        PH_0,  PH_1,  PH_2,  PH_3,  PH_4,  PH_5,  PH_6,  PH_7,
        PH_8,  PH_9,  PH_10, PH_11, PH_12, PH_13, PH_14, PH_15
    } phase_e;

    typedef enum logic [1:0] {
        HOST_RD  = 2'd0,                    // Read one RAM byte
        HOST_WR  = 2'd1,                    // Write one RAM byte
        HOST_KBD = 2'd2,                    // Load keyboard row, addr[3:0] picks the row
        HOST_CTL = 2'd3                     // Bit 0 releases CPU reset, bit 1 sets ready
    } host_op_e;

    typedef struct packed {
        host_op_e    op;
        logic [16:0] addr;                  // Full RAM address, no mirroring applied
        logic [7:0]  data;                  // Write data or keyboard row bits
    } host_cmd_t;

    typedef struct packed {
        host_op_e   op;                     // Echo of the command opcode
        logic [7:0] data;                   // Read data, zero for all other ops
    } host_rsp_t;

    typedef struct packed {
        logic [15:0] addr;
        logic        rw_n;                  // 1 = CPU reading
        logic [7:0]  data;                  // CPU write data
        logic        sync;                  // Opcode fetch
    } cpu_bus_t;

    typedef struct packed {
        logic ram;
        logic io;                           // Whole E8xx page
        logic pia1;
        logic pia2;
        logic via;
    } dev_sel_t;

    typedef struct packed {
        logic [16:0] addr;
        logic [7:0]  wdata;
        logic        we;
        logic        oe;
        logic        ce;
    } ram_req_t;

    localparam logic [15:0] VRAM_BASE     = 16'h8000;
    localparam logic [15:0] IO_BASE       = 16'hE800;
    localparam logic [15:0] PIA1_BASE     = 16'hE810;  // Keyboard PIA
    localparam logic [15:0] PIA2_BASE     = 16'hE820;
    localparam logic [15:0] VIA_BASE      = 16'hE840;
    localparam logic [15:0] KBD_PORTB_OFS = 16'h0002;  // Port B read returns the row
    localparam int          KBD_ROWS      = 10;

endpackage

`default_nettype wire

// File: rtl/slot_timing.sv
// One 16-cycle frame per 1 MHz CPU cycle
// Phases 0..7 belong to the host, phases 8..15 to the CPU
// All outputs are registers aligned with phase_o
`timescale 1ns/1ns
`default_nettype none

module slot_timing (
    input  wire logic       clk_16_i,
    input  wire logic       rst_n_i,
    output pet_pkg::phase_e phase_o,
    output logic            clk_cpu_o,
    output logic            host_slot_o,
    output logic            cpu_slot_o
);
    import pet_pkg::*;

    logic [3:0] cnt_q;                      // Frame counter
    logic [3:0] cnt_nxt;

    assign cnt_nxt = cnt_q + 4'd1;          // Wraps 15 to 0
    assign phase_o = phase_e'(cnt_q);

    // Strobes come from the next count so they line up with phase_o
    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q       <= 4'd0;
            clk_cpu_o   <= 1'b0;
            host_slot_o <= 1'b1;            // Phase 0 is in the host slot
            cpu_slot_o  <= 1'b0;
        end else begin
            cnt_q       <= cnt_nxt;
            clk_cpu_o   <= cnt_nxt[3];      // High in phases 8..15
            host_slot_o <= !cnt_nxt[3];
            cpu_slot_o  <= cnt_nxt[3];
        end
    end

    a_slots_exclusive: assert property (
        @(posedge clk_16_i) disable iff (!rst_n_i)
        !(host_slot_o && cpu_slot_o)
    );

endmodule

`default_nettype wire

// File: rtl/addr_decode.sv
// CPU address decoder, purely combinational
// 9000..E7FF and F000..FFFF are ROM images held in RAM and flagged read-only
// E900..EFFF selects nothing
// VRAM_KB must be 1 or 2, any other value behaves as 2
`timescale 1ns/1ns
`default_nettype none

module addr_decode #(
    parameter int VRAM_KB = 1               // Video RAM size in KB
) (
    input  wire logic [15:0] addr_i,
    output pet_pkg::dev_sel_t sel_o,
    output logic             readonly_o,
    output logic             mirrored_o,
    output logic [1:0]       mirror_mask_o
);
    import pet_pkg::*;

    localparam logic [15:0] ROM_BASE    = 16'h9000;  // BASIC and editor ROM
    localparam logic [15:0] KERNAL_BASE = 16'hF000;  // Kernal ROM

    localparam logic [15:0] VRAM_MASK = 16'hF000;    // 4 KB window
    localparam logic [15:0] IO_MASK   = 16'hFF00;    // 256 byte page
    localparam logic [15:0] PIA1_MASK = 16'hFFF0;    // 16 bytes
    localparam logic [15:0] PIA2_MASK = 16'hFFE0;    // 32 bytes
    localparam logic [15:0] VIA_MASK  = 16'hFFC0;    // 64 bytes

    // 1 KB mirrors 4 times, 2 KB mirrors twice
    localparam logic [1:0] MIRROR_MASK = (VRAM_KB == 1) ? 2'b11 : 2'b10;

    always_comb begin
        sel_o.ram  = (addr_i < IO_BASE) || (addr_i >= KERNAL_BASE);
        sel_o.io   = (addr_i & IO_MASK) == IO_BASE;
        sel_o.pia1 = (addr_i & PIA1_MASK) == PIA1_BASE;
        sel_o.pia2 = (addr_i & PIA2_MASK) == PIA2_BASE;
        sel_o.via  = (addr_i & VIA_MASK) == VIA_BASE;

        readonly_o = sel_o.ram && (addr_i >= ROM_BASE);  // Both ROM ranges
        mirrored_o = (addr_i & VRAM_MASK) == VRAM_BASE;  // 8000..8FFF
    end

    // Constant mask, top applies it only when mirrored_o is set
    assign mirror_mask_o = MIRROR_MASK;

endmodule

`default_nettype wire

// File: rtl/kbd_matrix.sv
// Keyboard matrix seen by the CPU through PIA1
// Host loads rows with 1 = key down, the CPU sees them inverted
// Column register is the low nibble of port A, port B reads are intercepted
// pia1_sel_i must already be gated to the CPU slot
`timescale 1ns/1ns
`default_nettype none

module kbd_matrix (
    input  wire logic              clk_16_i,
    input  wire logic              rst_n_i,
    input  wire logic              row_wr_i,
    input  wire logic [3:0]        row_idx_i,
    input  wire logic [7:0]        row_data_i,
    input  wire pet_pkg::cpu_bus_t cpu_bus_i,
    input  wire logic              pia1_sel_i,
    input  wire logic              cpu_wr_stb_i,
    output logic [7:0]             kbd_data_o,
    output logic                   kbd_hit_o
);
    import pet_pkg::*;

    localparam logic [1:0] PORTA_OFS = 2'd0;

    logic [7:0] rows_q [KBD_ROWS];          // One byte per matrix row
    logic [3:0] col_q;                      // Row select written by the CPU
    logic       row_ok;
    logic       porta_wr;
    logic       col_ok;

    assign row_ok   = row_idx_i < 4'(KBD_ROWS);  // Drop loads past the last row
    assign col_ok   = col_q < 4'(KBD_ROWS);
    assign porta_wr = cpu_wr_stb_i && pia1_sel_i && !cpu_bus_i.rw_n
                      && (cpu_bus_i.addr[1:0] == PORTA_OFS);

    // Reset to no keys pressed
    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < KBD_ROWS; i++) begin
                rows_q[i] <= 8'h00;
            end
        end else if (row_wr_i && row_ok) begin
            rows_q[row_idx_i] <= row_data_i;
        end
    end

    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            col_q <= 4'd0;
        end else if (porta_wr) begin
            col_q <= cpu_bus_i.data[3:0];   // Upper nibble drives other PET lines
        end
    end

    // Port B read, data replaces the PIA
    assign kbd_hit_o = pia1_sel_i && cpu_bus_i.rw_n
                       && (cpu_bus_i.addr[1:0] == KBD_PORTB_OFS[1:0]);

    always_comb begin
        if (col_ok) begin
            kbd_data_o = ~rows_q[col_q];    // Keys are active low on the bus
        end else begin
            kbd_data_o = 8'hFF;             // No row driven, nothing pressed
        end
    end

endmodule

`default_nettype wire

// File: rtl/host_port.sv
// Host command queue with credit return
// At most one command runs per frame, in the host slot
// Phase 0 latches the head, RAM access in phases 1..3, retire at the phase 3 edge
// Response and credit are both high for phase 4 only
// HOST_DEPTH from 2 to 8, any depth, not only powers of two
`timescale 1ns/1ns
`default_nettype none

module host_port #(
    parameter int HOST_DEPTH = 4            // Queue entries and initial host credits
) (
    input  wire logic               clk_16_i,
    input  wire logic               rst_n_i,
    input  wire pet_pkg::host_cmd_t host_cmd_i,
    input  wire logic               host_cmd_valid_i,
    input  wire pet_pkg::phase_e    phase_i,
    input  wire logic [7:0]         ram_rdata_i,
    output pet_pkg::host_rsp_t      host_rsp_o,
    output logic                    host_rsp_valid_o,
    output logic                    host_credit_o,
    output pet_pkg::ram_req_t       host_ram_o,
    output logic                    host_busy_o,
    output logic                    kbd_wr_o,
    output logic [3:0]              kbd_idx_o,
    output logic [7:0]              kbd_data_o,
    output logic                    cpu_res_no,
    output logic                    cpu_ready_o
);
    import pet_pkg::*;

    localparam int PW = $clog2(HOST_DEPTH);      // Pointer width
    localparam int CW = $clog2(HOST_DEPTH + 1);  // Count width

    host_cmd_t     fifo_q [HOST_DEPTH];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [CW-1:0] cnt_q;
    logic          run_q;                   // Head command owns this host slot
    logic          retire;
    logic          ram_op;
    host_cmd_t     head;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        if (ptr == PW'(HOST_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head   = fifo_q[rd_ptr_q];
    assign ram_op = (head.op == HOST_RD) || (head.op == HOST_WR);
    assign retire = run_q && (phase_i == PH_3);  // Read data sampled on this edge

    always_ff @(posedge clk_16_i) begin
        if (host_cmd_valid_i) begin
            fifo_q[wr_ptr_q] <= host_cmd_i;
        end
    end

    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (host_cmd_valid_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (retire) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            cnt_q <= cnt_q + CW'(host_cmd_valid_i) - CW'(retire);
        end
    end

    // Commands pushed after phase 0 wait for the next frame
    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q <= 1'b0;
        end else if ((phase_i == PH_0) && (cnt_q != '0)) begin
            run_q <= 1'b1;
        end else if (retire) begin
            run_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            host_rsp_valid_o <= 1'b0;
            host_credit_o    <= 1'b0;
            cpu_res_no       <= 1'b0;       // CPU held in reset until host says so
            cpu_ready_o      <= 1'b0;
        end else begin
            host_rsp_valid_o <= retire;
            host_credit_o    <= retire;     // Entry freed, one credit back
            if (retire && (head.op == HOST_CTL)) begin
                cpu_res_no  <= head.data[0];
                cpu_ready_o <= head.data[1];
            end
        end
    end

    always_ff @(posedge clk_16_i) begin
        if (retire) begin
            host_rsp_o.op   <= head.op;
            host_rsp_o.data <= (head.op == HOST_RD) ? ram_rdata_i : 8'h00;
        end
    end

    assign host_busy_o = run_q && ram_op;   // Phases 1..3 only

    always_comb begin
        host_ram_o.addr  = head.addr;
        host_ram_o.wdata = head.data;
        host_ram_o.ce    = host_busy_o;
        host_ram_o.oe    = host_busy_o && (head.op == HOST_RD);
        host_ram_o.we    = host_busy_o && (head.op == HOST_WR);
    end

    assign kbd_wr_o   = retire && (head.op == HOST_KBD);
    assign kbd_idx_o  = head.addr[3:0];
    assign kbd_data_o = head.data;

    // A push into a full queue means the host sent without a credit
    a_no_overflow: assert property (
        @(posedge clk_16_i) disable iff (!rst_n_i)
        host_cmd_valid_i |-> (cnt_q < CW'(HOST_DEPTH))
    );

    a_rsp_pending: assert property (
        @(posedge clk_16_i) disable iff (!rst_n_i)
        host_rsp_valid_o |-> (phase_i == PH_4) && $past(cnt_q != '0)
    );

endmodule

`default_nettype wire

// File: rtl/pet_bus_top.sv
// PET bus controller top, joins timing, decode, keyboard and host queue
// ram_req_o.addr is the raw address, ram_addr_hi_o carries the mirrored A11..A10
// CPU selects are valid in phases 9..15 and only while cpu_ready_o is high
`timescale 1ns/1ns
`default_nettype none

module pet_bus_top #(
    parameter int VRAM_KB    = 1,
    parameter int HOST_DEPTH = 4
) (
    input  wire logic               clk_16_i,
    input  wire logic               rst_n_i,
    input  wire pet_pkg::host_cmd_t host_cmd_i,
    input  wire logic               host_cmd_valid_i,
    output logic                    host_credit_o,
    output pet_pkg::host_rsp_t      host_rsp_o,
    output logic                    host_rsp_valid_o,
    input  wire pet_pkg::cpu_bus_t  cpu_bus_i,
    output logic [7:0]              cpu_rdata_o,
    output logic                    clk_cpu_o,
    output logic                    cpu_res_no,
    output logic                    cpu_ready_o,
    output logic                    pia1_cs_no,
    output logic                    pia2_cs_no,
    output logic                    via_cs_no,
    output logic                    io_oe_no,
    output pet_pkg::ram_req_t       ram_req_o,
    output logic [11:10]            ram_addr_hi_o,
    input  wire logic [7:0]         ram_rdata_i
);
    import pet_pkg::*;

    phase_e     phase;
    logic       host_slot;
    logic       cpu_slot;
    dev_sel_t   dec_sel;
    dev_sel_t   sel;
    logic       readonly;
    logic       mirrored;
    logic [1:0] mirror_mask;
    ram_req_t   host_ram;
    ram_req_t   cpu_ram;
    logic       host_busy;
    logic       use_host;
    logic       kbd_wr;
    logic [3:0] kbd_idx;
    logic [7:0] kbd_row;
    logic [7:0] kbd_rdata;
    logic       kbd_hit;
    logic       cpu_en;
    logic       cpu_we_win;

    slot_timing u_timing (
        .clk_16_i, .rst_n_i, .phase_o(phase), .clk_cpu_o,
        .host_slot_o(host_slot), .cpu_slot_o(cpu_slot)
    );

    addr_decode #(.VRAM_KB(VRAM_KB)) u_decode (
        .addr_i(cpu_bus_i.addr), .sel_o(dec_sel), .readonly_o(readonly),
        .mirrored_o(mirrored), .mirror_mask_o(mirror_mask)
    );

    kbd_matrix u_kbd (
        .clk_16_i, .rst_n_i, .row_wr_i(kbd_wr), .row_idx_i(kbd_idx), .row_data_i(kbd_row),
        .cpu_bus_i, .pia1_sel_i(sel.pia1), .cpu_wr_stb_i(phase == PH_14),
        .kbd_data_o(kbd_rdata), .kbd_hit_o(kbd_hit)
    );

    host_port #(.HOST_DEPTH(HOST_DEPTH)) u_host (
        .clk_16_i, .rst_n_i, .host_cmd_i, .host_cmd_valid_i, .phase_i(phase), .ram_rdata_i,
        .host_rsp_o, .host_rsp_valid_o, .host_credit_o, .host_ram_o(host_ram),
        .host_busy_o(host_busy), .kbd_wr_o(kbd_wr), .kbd_idx_o(kbd_idx),
        .kbd_data_o(kbd_row), .cpu_res_no, .cpu_ready_o
    );

    assign cpu_en     = cpu_slot && (phase != PH_8) && cpu_ready_o;  // Address settles in phase 8
    assign cpu_we_win = (phase >= PH_12) && (phase <= PH_14);
    assign sel        = cpu_en ? dec_sel : '0;

    // Keyboard intercept keeps PIA1 and the IO buffer off the bus
    assign pia1_cs_no = !(sel.pia1 && !kbd_hit);
    assign io_oe_no   = !(sel.io && !kbd_hit);
    assign pia2_cs_no = !sel.pia2;
    assign via_cs_no  = !sel.via;

    always_comb begin
        cpu_ram.addr  = {1'b0, cpu_bus_i.addr};  // CPU sees the lower 64 KB
        cpu_ram.wdata = cpu_bus_i.data;
        cpu_ram.ce    = sel.ram;
        cpu_ram.oe    = sel.ram && cpu_bus_i.rw_n;
        cpu_ram.we    = sel.ram && !cpu_bus_i.rw_n && !readonly && cpu_we_win;
    end

    assign use_host      = host_slot && host_busy;
    assign ram_req_o     = use_host ? host_ram : cpu_ram;
    assign ram_addr_hi_o = use_host ? host_ram.addr[11:10]        // Host sees the full RAM
                         : cpu_bus_i.addr[11:10] & ~(mirror_mask & {2{mirrored}});

    assign cpu_rdata_o = kbd_hit ? kbd_rdata : ram_rdata_i;

endmodule

`default_nettype wire

// File: verif/pet_bus_tb.sv
// Runs the PET bus controller with VRAM_KB 1 and HOST_DEPTH 4
// Reads its steps from verif/pet_bus_stimulus.txt relative to the project root
// RAM is a 128 KB array indexed with the mirrored A11..A10 from the DUT
// Host commands are queued on credits
// A CPU step first drains all responses
`timescale 1ns/1ns
`default_nettype none

module pet_bus_tb;
    import pet_pkg::*;

    localparam int VRAM_KB    = 1;
    localparam int HOST_DEPTH = 4;
    localparam int FRAME_NS   = 64;         // 16 phases of 4 ns
    localparam int MAX_STEPS  = 64;

    logic       clk_16_i = 1'b0;
    logic       rst_n_i;
    host_cmd_t  host_cmd_i;
    logic       host_cmd_valid_i;
    logic       host_credit_o;
    host_rsp_t  host_rsp_o;
    logic       host_rsp_valid_o;
    cpu_bus_t   cpu_bus_i;
    logic [7:0] cpu_rdata_o;
    logic       clk_cpu_o;
    logic       cpu_res_no;
    logic       cpu_ready_o;
    logic       pia1_cs_no;
    logic       pia2_cs_no;
    logic       via_cs_no;
    logic       io_oe_no;
    ram_req_t   ram_req_o;
    logic [11:10] ram_addr_hi_o;
    logic [7:0] ram_rdata_i;

    logic [7:0]  ram_mem [0:131071];        // External SRAM model
    logic [16:0] ram_idx;

    logic [31:0] st_kind [MAX_STEPS];       // Parsed stimulus columns
    logic [31:0] st_op   [MAX_STEPS];
    logic [16:0] st_addr [MAX_STEPS];
    logic [7:0]  st_data [MAX_STEPS];
    logic [7:0]  st_exp  [MAX_STEPS];
    logic [4:0]  st_sel  [MAX_STEPS];
    int          n_steps = 0;

    host_rsp_t exp_q[$];                    // Expected responses in command order
    int        step_q[$];
    int        sent = 0;
    int        rsp_cnt = 0;
    int        credits_ret = 0;
    int        errors = 0;
    logic [7:0] last_fill;

    always #2 clk_16_i = ~clk_16_i;

    pet_bus_top #(.VRAM_KB(VRAM_KB), .HOST_DEPTH(HOST_DEPTH)) dut0 (.*);

    assign ram_idx     = {ram_req_o.addr[16:12], ram_addr_hi_o, ram_req_o.addr[9:0]};
    assign ram_rdata_i = ram_mem[ram_idx];  // Asynchronous read

    always @(posedge clk_16_i) begin
        if (ram_req_o.ce && ram_req_o.we) begin
            ram_mem[ram_idx] <= ram_req_o.wdata;
        end
    end

    task automatic check_rsp(input host_rsp_t got, input host_rsp_t exp, input int step);
        if (got !== exp) begin
            $display("ERR %0t: step %0d response %h, expected %h", $time, step, got, exp);
            errors++;
        end else begin
            $display("step %0d host op %0d data %h ok", step, got.op, got.data);
        end
    endtask

    task automatic check_sel(input dev_sel_t got, input dev_sel_t exp, input int step);
        if (got !== exp) begin
            $display("ERR %0t: step %0d selects %b, expected %b", $time, step, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int step);
        if (got !== exp) begin
            $display("ERR %0t: step %0d byte %h, expected %h", $time, step, got, exp);
            errors++;
        end
    endtask

    // Counts credits and checks responses on pre-edge DUT values
    always @(posedge clk_16_i) begin
        if (rst_n_i) begin
            if (host_credit_o) begin
                credits_ret <= credits_ret + 1;
            end
            if (host_rsp_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("Response arrived with no command outstanding at %0t", $time);
                    errors++;
                end else begin
                    check_rsp(host_rsp_o, exp_q.pop_front(), step_q.pop_front());
                end
                rsp_cnt <= rsp_cnt + 1;
            end
        end
    end

    task automatic send_host(input host_cmd_t cmd, input host_rsp_t exp, input int step);
        @(posedge clk_16_i);
        while (sent - credits_ret >= HOST_DEPTH) begin  // Out of credits
            @(posedge clk_16_i);
        end
        host_cmd_i       <= cmd;
        host_cmd_valid_i <= 1'b1;
        exp_q.push_back(exp);
        step_q.push_back(step);
        sent++;
        @(posedge clk_16_i);
        host_cmd_valid_i <= 1'b0;
    endtask

    task automatic drain_host();
        while (rsp_cnt != sent) begin
            @(posedge clk_16_i);
        end
        if (credits_ret != sent) begin
            $display("ERR %0t: %0d credits back for %0d commands", $time, credits_ret, sent);
            errors++;
        end
    endtask

    // One 6502 cycle with the bus set in the host slot and sampled in phase 15
    task automatic run_cpu(input cpu_bus_t bus, output dev_sel_t sel, output logic [7:0] rd);
        @(negedge clk_cpu_o);
        @(posedge clk_16_i);
        cpu_bus_i <= bus;
        @(posedge clk_cpu_o);               // Phase 8
        repeat (7) @(posedge clk_16_i);
        @(negedge clk_16_i);
        sel.ram  = ram_req_o.ce;
        sel.io   = !io_oe_no;
        sel.pia1 = !pia1_cs_no;
        sel.pia2 = !pia2_cs_no;
        sel.via  = !via_cs_no;
        rd       = cpu_rdata_o;
        @(posedge clk_16_i);
        cpu_bus_i <= '{addr: 16'h0000, rw_n: 1'b1, data: 8'h00, sync: 1'b0};
    endtask

    task automatic load_steps();
        int fd;
        int n;
        logic [8*96-1:0] line;
        fd = $fopen("verif/pet_bus_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd) && n_steps < MAX_STEPS) begin
                line = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %s %h %h %h %h", st_kind[n_steps], st_op[n_steps],
                            st_addr[n_steps], st_data[n_steps], st_exp[n_steps],
                            st_sel[n_steps]);
                if (n == 6) begin           // Comments and blank lines fall out here
                    n_steps++;
                end
            end
            $fclose(fd);
            if (n_steps == 0) begin
                $display("The stimulus file holds no steps");
                errors++;
            end
        end
    endtask

    // Watchdog scaled to the number of steps
    initial begin
        int wd_ns;
        wait (n_steps != 0);
        wd_ns = (n_steps * (HOST_DEPTH + 2) + 32) * FRAME_NS;
        #(wd_ns * 1ns);
        $display("Timeout, the run did not finish within %0d ns", wd_ns);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        host_cmd_t  cmd;
        host_rsp_t  exp;
        dev_sel_t   sel;
        logic [7:0] rd;
        void'($urandom(32'h82f81a84));
        rst_n_i          = 1'b0;
        host_cmd_i       = '0;
        host_cmd_valid_i = 1'b0;
        cpu_bus_i        = '{addr: 16'h0000, rw_n: 1'b1, data: 8'h00, sync: 1'b0};
        for (int i = 0; i < 131072; i++) begin
            ram_mem[i] = 8'(i) ^ 8'(i >> 8) ^ {i[16], 7'd0};  // Pattern over all 17 bits
        end
        load_steps();
        repeat (16) @(posedge clk_16_i);
        rst_n_i <= 1'b1;
        for (int s = 0; s < n_steps; s++) begin
            if (st_kind[s] == "H") begin
                cmd.addr = st_addr[s];
                cmd.data = st_data[s];
                exp.data = 8'h00;           // Only reads return data
                case (st_op[s])
                    "RD": begin
                        cmd.op   = HOST_RD;
                        exp.data = st_exp[s];
                    end
                    "RDF": begin
                        cmd.op   = HOST_RD;
                        exp.data = last_fill;
                    end
                    "WR":    cmd.op = HOST_WR;
                    "FILL": begin
                        cmd.op    = HOST_WR;
                        last_fill = 8'($urandom);
                        cmd.data  = last_fill;
                    end
                    "KBD":   cmd.op = HOST_KBD;
                    default: cmd.op = HOST_CTL;
                endcase
                exp.op = cmd.op;
                send_host(cmd, exp, s);
            end else begin
                drain_host();
                if (st_op[s] == "ST") begin
                    check_byte({6'd0, cpu_ready_o, cpu_res_no}, st_exp[s], s);
                end else begin
                    run_cpu('{addr: st_addr[s][15:0], rw_n: (st_op[s] == "RD"),
                              data: st_data[s], sync: 1'b0}, sel, rd);
                    check_sel(sel, dev_sel_t'(st_sel[s]), s);
                    if (st_op[s] == "RD") begin
                        check_byte(rd, st_exp[s], s);
                    end
                end
                $display("step %0d cpu %0s %h done", s, st_op[s], st_addr[s]);
            end
        end
        drain_host();
        $display("steps %0d commands %0d responses %0d credits %0d errors %0d",
                 n_steps, sent, rsp_cnt, credits_ret, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/pet_bus_stimulus.txt
# kind op addr data expect sel, all hex; expect is the read byte or {ready,res_n}
# sel bits are ram io pia1 pia2 via; H ops RD WR KBD CTL FILL RDF, C ops RD WR ST
C ST   0000  00 00 00
C WR   1234  77 00 00
C WR   E810  03 00 00
H WR   00100 A5 00 00
H RD   00100 00 A5 00
H WR   00200 11 00 00
H WR   00201 22 00 00
H WR   00202 33 00 00
H WR   00203 44 00 00
H WR   00204 55 00 00
H RD   00202 00 33 00
H RD   00204 00 55 00
H RD   1ABCD 00 E6 00
H CTL  00000 03 00 00
C ST   0000  00 03 00
H WR   0C000 E7 00 00
C WR   1234  5A 00 10
C WR   C000  99 00 10
H RD   01234 00 5A 00
H RD   0C000 00 E7 00
C WR   8400  3C 00 10
H RD   08000 00 3C 00
C RD   8400  00 3C 10
C WR   E820  00 00 0A
C RD   E840  00 A8 09
H KBD  00003 21 00 00
C WR   E810  03 00 0C
C RD   E812  00 DE 00
H FILL 1F000 00 00 00
H RDF  1F000 00 00 00

// File: sources.f
rtl/pet_pkg.sv
rtl/slot_timing.sv
rtl/addr_decode.sv
rtl/kbd_matrix.sv
rtl/host_port.sv
rtl/pet_bus_top.sv
verif/pet_bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PET bus controller testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module pet_bus_tb \
    -f sources.f \
    --Mdir obj_dir \
    -o pet_bus_sim

./obj_dir/pet_bus_sim | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation finished, log in sim.log"
exit 0
